/* src/aes_pkg.sv */
package aes_pkg;

    localparam int block_width   = 128;
    localparam int word_width    = 32;
    localparam int max_key_words = 8;
    localparam int max_rounds    = 14;

    typedef logic [block_width-1:0] block_t;
    typedef logic [word_width-1:0]  word_t;
    typedef logic [3:0]             round_idx_t;

    typedef enum logic [2:0] {
        OP_IDLE,
        OP_LOAD,
        OP_ARK,
        OP_SUB,
        OP_SHIFT,
        OP_MIX
    } state_op_e;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_KEY_WAIT,
        ST_ARK_INIT,
        ST_SUB,
        ST_SHIFT,
        ST_MIX,
        ST_ARK,
        ST_SUB_FINAL,
        ST_SHIFT_FINAL,
        ST_ARK_FINAL,
        ST_SEND
    } ctrl_state_e;

    // forward S-box, entry 0x00 in the top byte
    localparam logic [2047:0] sbox_table = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [7:0] s_box(input logic [7:0] b);
        return sbox_table[8 * (255 - int'(b)) +: 8];
    endfunction

    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic word_t sub_word(input word_t w);
        return {s_box(w[31:24]), s_box(w[23:16]), s_box(w[15:8]), s_box(w[7:0])};
    endfunction

    function automatic word_t rot_word(input word_t w);
        return {w[23:0], w[31:24]};
    endfunction

    // step counts from 1, as in i / Nk
    function automatic word_t rcon(input logic [3:0] step);
        logic [7:0] rc;
        rc = 8'h01;
        for (int k = 2; k <= 10; k++) begin
            if (k <= int'(step)) begin
                rc = xtime(rc);
            end
        end
        return {rc, 24'h000000};
    endfunction

    function automatic int num_rounds(input int key_words);
        return key_words + 6;
    endfunction

endpackage

/* src/aes_key_if.sv */
interface aes_key_if;
    import aes_pkg::*;

    logic       start;      // new block accepted
    logic       done;       // last schedule word being written
    round_idx_t round;
    block_t     round_key;  // words 4*round .. 4*round+3

    modport ctrl     (output start, input done);
    modport counter  (output round);
    modport sched    (input start, input round, output done, output round_key);
    modport datapath (input round_key);

endinterface

/* src/aes_ctrl_fsm.sv */
module aes_ctrl_fsm (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               ready_i,
    aes_key_if.ctrl            key_if,
    input  logic               final_round_i,
    output aes_pkg::state_op_e state_op_o,
    output logic               round_clear_o,
    output logic               round_step_o,
    output logic               done_o
);
    import aes_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        done_q;

    always_comb begin
        state_d       = state_q;
        state_op_o    = OP_IDLE;
        key_if.start  = 1'b0;
        round_clear_o = 1'b0;
        round_step_o  = 1'b0;
        unique case (state_q)
            ST_IDLE: begin
                if (ready_i) begin
                    state_op_o    = OP_LOAD;
                    key_if.start  = 1'b1;
                    round_clear_o = 1'b1;
                    state_d       = ST_KEY_WAIT;
                end
            end
            ST_KEY_WAIT: begin
                if (key_if.done) state_d = ST_ARK_INIT;
            end
            ST_ARK_INIT: begin
                state_op_o   = OP_ARK;  // whitening with round 0
                round_step_o = 1'b1;
                state_d      = ST_SUB;
            end
            ST_SUB: begin
                state_op_o = OP_SUB;
                state_d    = ST_SHIFT;
            end
            ST_SHIFT: begin
                state_op_o = OP_SHIFT;
                state_d    = ST_MIX;
            end
            ST_MIX: begin
                state_op_o = OP_MIX;
                state_d    = ST_ARK;
            end
            ST_ARK: begin
                state_op_o   = OP_ARK;
                round_step_o = 1'b1;
                state_d      = final_round_i ? ST_SUB_FINAL : ST_SUB;
            end
            ST_SUB_FINAL: begin
                state_op_o = OP_SUB;
                state_d    = ST_SHIFT_FINAL;
            end
            ST_SHIFT_FINAL: begin
                state_op_o = OP_SHIFT;
                state_d    = ST_ARK_FINAL;
            end
            ST_ARK_FINAL: begin
                state_op_o = OP_ARK;  // no step, round stays at the last key
                state_d    = ST_SEND;
            end
            ST_SEND: state_d = ST_IDLE;  // idle opcode here latches the result
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= (state_q == ST_SEND);
        end
    end

    assign done_o = done_q;

    a_start_only_idle : assert property (
        @(posedge clk_i) disable iff (!rst_ni) $rose(key_if.start) |-> state_q == ST_IDLE);

    // the schedule must finish exactly while we wait for it
    a_sched_done_in_wait : assert property (
        @(posedge clk_i) disable iff (!rst_ni) key_if.done |-> state_q == ST_KEY_WAIT);

endmodule

/* src/aes_round_counter.sv */
module aes_round_counter #(
    parameter int NUM_ROUNDS = 14
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       clear_i,
    input  logic       step_i,
    aes_key_if.counter key_if,
    output logic       final_round_o
);
    import aes_pkg::*;

    round_idx_t round_q;
    round_idx_t round_d;

    always_comb begin
        round_d = round_q;
        if (clear_i) begin
            round_d = '0;
        end else if (step_i) begin
            round_d = round_q + 4'd1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) round_q <= '0;
        else round_q <= round_d;
    end

    assign key_if.round = round_q;
    // includes a step in flight, so the FSM can branch on the ARK edge itself
    assign final_round_o = (round_d == round_idx_t'(NUM_ROUNDS));

    a_no_step_past_last : assert property (
        @(posedge clk_i) disable iff (!rst_ni) step_i |-> round_q != round_idx_t'(NUM_ROUNDS));

endmodule

/* src/aes_key_expand.sv */
module aes_key_expand #(
    parameter int KEY_WORDS = 8
) (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  logic [aes_pkg::word_width*KEY_WORDS-1:0] cipher_key_i,
    aes_key_if.sched                               key_if
);
    import aes_pkg::*;

    localparam int store_words = 4 * (max_rounds + 1);
    localparam int total_words = 4 * (num_rounds(KEY_WORDS) + 1);
    localparam int pos_width   = $clog2(max_key_words);

    word_t                mem_q [store_words];
    logic [5:0]           idx_q;   // next word to write
    logic [pos_width-1:0] pos_q;   // idx mod KEY_WORDS
    logic [3:0]           rc_q;    // idx div KEY_WORDS
    logic                 busy_q;
    word_t                prev_word;
    word_t                mixed_word;
    word_t                new_word;

    always_comb begin
        prev_word = mem_q[idx_q - 6'd1];
        if (pos_q == '0) begin
            mixed_word = sub_word(rot_word(prev_word)) ^ rcon(rc_q);
        end else if (KEY_WORDS == 8 && pos_q == pos_width'(4)) begin
            mixed_word = sub_word(prev_word);  // extra step of the 256-bit schedule
        end else begin
            mixed_word = prev_word;
        end
        new_word = mem_q[idx_q - 6'(KEY_WORDS)] ^ mixed_word;
    end

    // word store, key words first, most significant word is w[0]
    always_ff @(posedge clk_i) begin
        if (key_if.start) begin
            for (int k = 0; k < KEY_WORDS; k++) begin
                mem_q[k] <= cipher_key_i[word_width*(KEY_WORDS-k)-1 -: word_width];
            end
        end else if (busy_q) begin
            mem_q[idx_q] <= new_word;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            idx_q  <= '0;
            pos_q  <= '0;
            rc_q   <= '0;
            busy_q <= 1'b0;
        end else if (key_if.start) begin
            idx_q  <= 6'(KEY_WORDS);
            pos_q  <= '0;
            rc_q   <= 4'd1;
            busy_q <= 1'b1;
        end else if (busy_q) begin
            idx_q <= idx_q + 6'd1;
            if (pos_q == pos_width'(KEY_WORDS - 1)) begin
                pos_q <= '0;
                rc_q  <= rc_q + 4'd1;
            end else begin
                pos_q <= pos_q + 1'b1;
            end
            if (idx_q == 6'(total_words - 1)) busy_q <= 1'b0;
        end
    end

    assign key_if.done = busy_q && (idx_q == 6'(total_words - 1));

    assign key_if.round_key = {mem_q[{key_if.round, 2'd0}],
                               mem_q[{key_if.round, 2'd1}],
                               mem_q[{key_if.round, 2'd2}],
                               mem_q[{key_if.round, 2'd3}]};

    a_idx_in_store : assert property (
        @(posedge clk_i) disable iff (!rst_ni) busy_q |-> idx_q < 6'(store_words));

    // a new block may only arrive once the previous schedule is complete
    a_no_start_while_busy : assert property (
        @(posedge clk_i) disable iff (!rst_ni) key_if.start |-> !busy_q);

endmodule

/* src/aes_state_unit.sv */
module aes_state_unit (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  aes_pkg::state_op_e state_op_i,
    input  aes_pkg::block_t    plain_text_i,
    aes_key_if.datapath        key_if,
    output aes_pkg::block_t    cipher_text_o
);
    import aes_pkg::*;

    block_t state_q;
    block_t sub_d;
    block_t shift_d;
    block_t mix_d;
    logic   ark_done_q;  // previous op was an AddRoundKey

    always_comb begin
        for (int b = 0; b < 16; b++) begin
            sub_d[8*b +: 8] = s_box(state_q[8*b +: 8]);
        end
    end

    // byte (row r, col c) sits at 127 - 8*(4c + r), row r rotates left by r
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shift_d[127 - 8*(4*c + r) -: 8] = state_q[127 - 8*(4*((c + r) % 4) + r) -: 8];
            end
        end
    end

    always_comb begin
        word_t      col;
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        for (int c = 0; c < 4; c++) begin
            col = state_q[127 - 32*c -: 32];
            a0  = col[31:24];
            a1  = col[23:16];
            a2  = col[15:8];
            a3  = col[7:0];
            // 3*x is xtime(x) ^ x
            mix_d[127 - 32*c -: 8]      = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
            mix_d[127 - 32*c - 8 -: 8]  = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
            mix_d[127 - 32*c - 16 -: 8] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
            mix_d[127 - 32*c - 24 -: 8] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_op_i)
            OP_LOAD:  state_q <= plain_text_i;
            OP_ARK:   state_q <= state_q ^ key_if.round_key;
            OP_SUB:   state_q <= sub_d;
            OP_SHIFT: state_q <= shift_d;
            OP_MIX:   state_q <= mix_d;
            default:  state_q <= state_q;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ark_done_q    <= 1'b0;
            cipher_text_o <= '0;
        end else begin
            ark_done_q <= (state_op_i == OP_ARK);
            // idle right after an ARK only follows the final round
            if (state_op_i == OP_IDLE && ark_done_q) begin
                cipher_text_o <= state_q;
            end
        end
    end

endmodule

/* src/aes_core.sv */
module aes_core #(
    parameter int KEY_WORDS = 8
) (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  logic                                   ready_i,
    input  aes_pkg::block_t                        plain_text_i,
    input  logic [aes_pkg::word_width*KEY_WORDS-1:0] cipher_key_i,
    output logic                                   done_o,
    output aes_pkg::block_t                        cipher_text_o
);
    import aes_pkg::*;

    localparam int NUM_ROUNDS = num_rounds(KEY_WORDS);

    state_op_e state_op;
    logic      round_clear;
    logic      round_step;
    logic      final_round;

    aes_key_if key_if ();

    aes_ctrl_fsm u_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .ready_i       (ready_i),
        .key_if        (key_if.ctrl),
        .final_round_i (final_round),
        .state_op_o    (state_op),
        .round_clear_o (round_clear),
        .round_step_o  (round_step),
        .done_o        (done_o)
    );

    aes_round_counter #(
        .NUM_ROUNDS (NUM_ROUNDS)
    ) u_round_counter (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .clear_i       (round_clear),
        .step_i        (round_step),
        .key_if        (key_if.counter),
        .final_round_o (final_round)
    );

    aes_key_expand #(
        .KEY_WORDS (KEY_WORDS)
    ) u_key_expand (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .cipher_key_i (cipher_key_i),
        .key_if       (key_if.sched)
    );

    aes_state_unit u_state_unit (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .state_op_i    (state_op),
        .plain_text_i  (plain_text_i),
        .key_if        (key_if.datapath),
        .cipher_text_o (cipher_text_o)
    );

endmodule

/* verif/tb_aes_core.sv */
module tb_aes_core;
    import aes_pkg::*;

    localparam int key_words = 8;
    localparam int rounds    = key_words + 6;
    // schedule words, whitening, full rounds, final round, output edge
    localparam int latency   = (4 * (rounds + 1) - key_words) + 1 + 4 * (rounds - 1) + 3 + 1;
    localparam int timeout   = 200;

    localparam int mode_quiet = 0;
    localparam int mode_noise = 1;  // random inputs and ready pulses while busy
    localparam int mode_chain = 2;  // next block held on the inputs with ready high

    typedef logic [32*key_words-1:0] key_t;

    logic   clk_i;
    logic   rst_ni;
    logic   ready_i;
    block_t plain_text_i;
    key_t   cipher_key_i;
    logic   done_o;
    block_t cipher_text_o;

    integer seed = 32'hcb52c6ce;
    block_t held_ct;  // value the output must keep until the next result
    block_t pt_q[$];
    key_t   key_q[$];
    block_t ct_q[$];

    aes_core aes_core_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .ready_i       (ready_i),
        .plain_text_i  (plain_text_i),
        .cipher_key_i  (cipher_key_i),
        .done_o        (done_o),
        .cipher_text_o (cipher_text_o)
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    task automatic check_block(input string name, input block_t expected, input block_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_logic(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic block_t random_block();
        block_t b;
        for (int k = 0; k < 4; k++) b[32*k +: 32] = $random(seed);
        return b;
    endfunction

    function automatic key_t random_key();
        key_t w;
        for (int k = 0; k < key_words; k++) w[32*k +: 32] = $random(seed);
        return w;
    endfunction

    task automatic load_vectors();
        int     fd;
        int     n;
        string  line;
        block_t pt;
        key_t   key;
        block_t ct;
        fd = $fopen("verif/aes_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file verif/aes_vectors.txt");
            $display("Test failed");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.substr(0, 0) != "#") begin
                if ($sscanf(line, "%h %h %h", pt, key, ct) == 3) begin
                    pt_q.push_back(pt);
                    key_q.push_back(key);
                    ct_q.push_back(ct);
                end
            end
        end
        $fclose(fd);
        if (pt_q.size() == 0) begin
            $display("the vector file holds no usable lines");
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic accept_block(input block_t pt, input key_t key);
        @(posedge clk_i);
        plain_text_i <= pt;
        cipher_key_i <= key;
        ready_i      <= 1'b1;
        @(posedge clk_i);  // accepting edge
        ready_i <= 1'b0;
    endtask

    task automatic wait_result(input string name, input block_t exp_ct, input int mode,
                               input block_t next_pt, input key_t next_key);
        int          edges;
        logic        seen;
        ctrl_state_e st;
        edges = 0;
        seen  = 1'b0;
        while (!seen) begin
            @(posedge clk_i);
            edges++;
            if (mode == mode_noise) begin
                plain_text_i <= random_block();
                cipher_key_i <= random_key();
                ready_i      <= (edges < latency - 8) && (edges % 9 == 4);
            end else if (mode == mode_chain) begin
                plain_text_i <= next_pt;
                cipher_key_i <= next_key;
                ready_i      <= 1'b1;
            end
            @(negedge clk_i);
            if (done_o) begin
                seen = 1'b1;
            end else begin
                check_block($sformatf("%s hold", name), held_ct, cipher_text_o);
                if (edges >= timeout) begin
                    st = aes_core_inst.u_ctrl.state_q;
                    $display("done_o never came for %s within %0d cycles, FSM in %s",
                             name, timeout, st.name());
                    $display("Test failed");
                    $fatal(1);
                end
            end
        end
        check_logic($sformatf("%s latency", name), latency, edges);
        check_block($sformatf("%s ciphertext", name), exp_ct, cipher_text_o);
        held_ct = exp_ct;
        // in chain mode this edge accepts the next block
        @(posedge clk_i);
        ready_i <= 1'b0;
        @(negedge clk_i);
        check_logic($sformatf("%s done pulse width", name), 0, done_o);
        check_block($sformatf("%s output after done", name), held_ct, cipher_text_o);
    endtask

    initial begin
        int     mode;
        logic   chained;
        block_t next_pt;
        key_t   next_key;
        rst_ni       <= 1'b0;
        ready_i      <= 1'b0;
        plain_text_i <= '0;
        cipher_key_i <= '0;
        held_ct = '0;
        load_vectors();
        for (int k = 0; k < 8; k++) begin
            @(posedge clk_i);
            @(negedge clk_i);
            check_logic("reset done_o", 0, done_o);
            check_block("reset cipher_text_o", '0, cipher_text_o);
        end
        @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_logic("post reset done_o", 0, done_o);
        check_block("post reset cipher_text_o", '0, cipher_text_o);

        chained = 1'b0;
        for (int i = 0; i < pt_q.size(); i++) begin
            next_pt  = '0;
            next_key = '0;
            if (i + 1 < pt_q.size() && i % 3 == 2) begin
                mode     = mode_chain;
                next_pt  = pt_q[i+1];
                next_key = key_q[i+1];
            end else if (i % 2 == 1) begin
                mode = mode_noise;
            end else begin
                mode = mode_quiet;
            end
            if (!chained) accept_block(pt_q[i], key_q[i]);
            wait_result($sformatf("vector %0d", i), ct_q[i], mode, next_pt, next_key);
            chained = (mode == mode_chain);
        end

        // no stray pulse once the inputs go quiet
        for (int k = 0; k < 20; k++) begin
            @(posedge clk_i);
            plain_text_i <= random_block();
            @(negedge clk_i);
            check_logic("idle done_o", 0, done_o);
            check_block("idle cipher_text_o", held_ct, cipher_text_o);
        end
        $display("Test passed");
        $finish;
    end

endmodule

/* verif/aes_vectors.txt */
# AES-256 known answers, one per line, hex fields
# plaintext (128 bit)  key (256 bit)  expected ciphertext (128 bit)
00112233445566778899aabbccddeeff 000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f 8ea2b7ca516745bfeafc49904b496089
00000000000000000000000000000000 0000000000000000000000000000000000000000000000000000000000000000 dc95c078a2408989ad48a21492842087
6bc1bee22e409f96e93d7e117393172a 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 f3eed1bdb5d2a03c064b5a7e3db181f8
ae2d8a571e03ac9c9eb76fac45af8e51 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 591ccb10d410ed26dc5ba74a31362870
30c81c46a35ce411e5fbc1191a0a52ef 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 b6ed21b99ca6f4f9f153e7b1beafed1d
f69f2445df4f9b17ad2b417be66c3710 603deb1015ca71be2b73aef0857d77811f352c073b6108d72d9810a30914dff4 23304b7a39f9f3ff067d8d8f9e24ecc7
014730f80ac625fe84f026c60bfd547d 0000000000000000000000000000000000000000000000000000000000000000 5c9d844ed46f9885085e5d6a4f94c7d7
80000000000000000000000000000000 0000000000000000000000000000000000000000000000000000000000000000 ddc6bf790c15760d8d9aeb6f9a75fd4e
00000000000000000000000000000000 c47b0294dbbbee0fec4757f22ffeee3587ca4730c3d33b691df38bab076bc558 46f2fb342d6f0ab477476fc501242c5f
00000000000000000000000000000000 8000000000000000000000000000000000000000000000000000000000000000 e35a6dcb19b201a01ebcfa8aa22b5759

/* verilog.f */
src/aes_pkg.sv
src/aes_key_if.sv
src/aes_ctrl_fsm.sv
src/aes_round_counter.sv
src/aes_key_expand.sv
src/aes_state_unit.sv
src/aes_core.sv
verif/tb_aes_core.sv

/* Bender.yml */
package:
  name: aes_core

sources:
  - src/aes_pkg.sv
  - src/aes_key_if.sv
  - src/aes_ctrl_fsm.sv
  - src/aes_round_counter.sv
  - src/aes_key_expand.sv
  - src/aes_state_unit.sv
  - src/aes_core.sv
  - target: test
    files:
      - verif/tb_aes_core.sv
